/* include/kmeans_params.svh */
`ifndef KMEANS_PARAMS_SVH
`define KMEANS_PARAMS_SVH

// datapath widths
`define KM_SAMPLE_W   16
`define KM_SUM_W      32
`define KM_ADDR_W     16

// image size and number of k-means passes
`define KM_NUM_PIXELS 100
`define KM_ITERATIONS 3

// a* below this value counts as strongly negative
`define KM_NEG_THRESH (-10)

// starting centroids
`define KM_C0_INIT    0
`define KM_C1_INIT    5

`endif

/* verilog/kmeans_pkg.sv */
`include "kmeans_params.svh"

package kmeans_pkg;

    // a* sample, also the centroid format
    typedef logic signed [`KM_SAMPLE_W-1:0] sample_t;

    // per-cluster running sum of samples
    typedef logic signed [`KM_SUM_W-1:0] sum_t;

    // pixel counts never exceed the image size
    typedef logic [`KM_ADDR_W-1:0] count_t;

    typedef logic [`KM_ADDR_W-1:0] addr_t;

endpackage

/* verilog/cluster_stats_if.sv */
`timescale 1ns/1ps

interface cluster_stats_if;
    import kmeans_pkg::*;

    // running totals per cluster
    sum_t   sum0;
    sum_t   sum1;
    count_t count0;
    count_t count1;

    // pixels below the strong-negative threshold
    count_t neg0;
    count_t neg1;

    modport accum (
        output sum0, sum1, count0, count1, neg0, neg1
    );

    modport divide (
        input sum0, sum1, count0, count1
    );

    // only the negative counts matter for cluster selection
    modport ctrl (
        input neg0, neg1
    );

endinterface

/* verilog/nearest_centroid.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module nearest_centroid (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  kmeans_pkg::sample_t sample,
    input  kmeans_pkg::sample_t c0,
    input  kmeans_pkg::sample_t c1,
    output logic                decision_valid,
    output logic                decision
);
    localparam int DIFF_W = `KM_SAMPLE_W + 1;

    // one extra bit so the difference cannot overflow
    logic signed [DIFF_W-1:0] diff0;
    logic signed [DIFF_W-1:0] diff1;
    logic        [DIFF_W-1:0] dist0;
    logic        [DIFF_W-1:0] dist1;

    assign diff0 = {sample[`KM_SAMPLE_W-1], sample} - {c0[`KM_SAMPLE_W-1], c0};
    assign diff1 = {sample[`KM_SAMPLE_W-1], sample} - {c1[`KM_SAMPLE_W-1], c1};

    // absolute distance orders the same as squared distance
    assign dist0 = diff0[DIFF_W-1] ? -diff0 : diff0;
    assign dist1 = diff1[DIFF_W-1] ? -diff1 : diff1;

    always_ff @(posedge clk)
    begin
        if (reset)
            decision_valid <= 1'b0;
        else
            decision_valid <= sample_valid;
    end

    // equal distance stays in cluster 0
    always_ff @(posedge clk)
    begin
        if (sample_valid)
            decision <= (dist1 < dist0);
    end

endmodule

/* verilog/cluster_accum.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module cluster_accum (
    input  logic                clk,
    input  logic                reset,
    input  logic                accum_clear,
    input  logic                decision_valid,
    input  logic                decision,
    input  kmeans_pkg::sample_t sample,
    cluster_stats_if.accum      stats
);
    import kmeans_pkg::*;

    logic strong_neg;
    sum_t sample_ext;

    assign strong_neg = (sample < sample_t'(`KM_NEG_THRESH));
    assign sample_ext = sum_t'(sample);

    always_ff @(posedge clk)
    begin
        if (reset || accum_clear)
        begin
            stats.sum0   <= '0;
            stats.sum1   <= '0;
            stats.count0 <= '0;
            stats.count1 <= '0;
            stats.neg0   <= '0;
            stats.neg1   <= '0;
        end
        else if (decision_valid)
        begin
            // sample is held by the controller until the decision lands
            if (decision)
            begin
                stats.sum1   <= stats.sum1 + sample_ext;
                stats.count1 <= stats.count1 + 1'b1;
                if (strong_neg)
                    stats.neg1 <= stats.neg1 + 1'b1;
            end
            else
            begin
                stats.sum0   <= stats.sum0 + sample_ext;
                stats.count0 <= stats.count0 + 1'b1;
                if (strong_neg)
                    stats.neg0 <= stats.neg0 + 1'b1;
            end
        end
    end

endmodule

/* verilog/centroid_divider.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module centroid_divider (
    input  logic                clk,
    input  logic                reset,
    input  logic                div_start,
    input  kmeans_pkg::sample_t c0,
    input  kmeans_pkg::sample_t c1,
    cluster_stats_if.divide     stats,
    output logic                div_done,
    output kmeans_pkg::sample_t new_c0,
    output kmeans_pkg::sample_t new_c1
);
    import kmeans_pkg::*;

    localparam int SUM_W  = `KM_SUM_W;
    localparam int DEN_W  = $bits(count_t);
    localparam int REM_W  = DEN_W + 1;
    localparam int STEP_W = $clog2(SUM_W);

    logic [REM_W-1:0]  rem0;
    logic [REM_W-1:0]  rem1;
    logic [SUM_W-1:0]  quo0;
    logic [SUM_W-1:0]  quo1;
    count_t            den0;
    count_t            den1;
    logic              neg0;
    logic              neg1;
    logic              busy;
    logic [STEP_W-1:0] step;

    // one restoring step, shifting the next dividend bit into the remainder
    function automatic logic [REM_W+SUM_W-1:0] div_step(
        input logic [REM_W-1:0] rem,
        input logic [SUM_W-1:0] quo,
        input count_t           den
    );
        logic [REM_W-1:0] rem_sh;
        logic [SUM_W-1:0] quo_sh;
        logic [REM_W:0]   trial;
        rem_sh = {rem[REM_W-2:0], quo[SUM_W-1]};
        quo_sh = {quo[SUM_W-2:0], 1'b0};
        trial  = {1'b0, rem_sh} - {2'b00, den};
        if (!trial[REM_W])
        begin
            rem_sh    = trial[REM_W-1:0];
            quo_sh[0] = 1'b1;
        end
        return {rem_sh, quo_sh};
    endfunction

    // quotient fits the sample range, the sign comes back last
    function automatic sample_t apply_sign(
        input logic [SUM_W-1:0] mag,
        input logic             negative
    );
        sample_t q;
        q = sample_t'(mag[`KM_SAMPLE_W-1:0]);
        return negative ? -q : q;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // both divisions step together, one quotient bit per cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            step     <= '0;
            div_done <= 1'b0;
        end
        else
        begin
            div_done <= 1'b0;
            if (div_start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (step == STEP_W'(SUM_W - 1))
                begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    // sign-magnitude operands captured at start
    always_ff @(posedge clk)
    begin
        if (div_start)
        begin
            rem0 <= '0;
            rem1 <= '0;
            quo0 <= stats.sum0[SUM_W-1] ? -stats.sum0 : stats.sum0;
            quo1 <= stats.sum1[SUM_W-1] ? -stats.sum1 : stats.sum1;
            neg0 <= stats.sum0[SUM_W-1];
            neg1 <= stats.sum1[SUM_W-1];
            den0 <= stats.count0;
            den1 <= stats.count1;
        end
        else if (busy)
        begin
            {rem0, quo0} <= div_step(rem0, quo0, den0);
            {rem1, quo1} <= div_step(rem1, quo1, den1);
        end
    end

    // an empty cluster keeps its old centroid
    assign new_c0 = (den0 == '0) ? c0 : apply_sign(quo0, neg0);
    assign new_c1 = (den1 == '0) ? c1 : apply_sign(quo1, neg1);

endmodule

/* verilog/kmeans_ctrl.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module kmeans_ctrl #(
    parameter int num_pixels = `KM_NUM_PIXELS,
    parameter int iterations = `KM_ITERATIONS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  kmeans_pkg::sample_t a_data,
    input  logic                cluster_id_rdata,
    input  logic                rgb_dark,
    input  logic                decision_valid,
    input  logic                decision,
    input  logic                div_done,
    input  kmeans_pkg::sample_t new_c0,
    input  kmeans_pkg::sample_t new_c1,
    output kmeans_pkg::addr_t   pixel_addr,
    output logic                sample_valid,
    output kmeans_pkg::sample_t sample,
    output kmeans_pkg::sample_t c0,
    output kmeans_pkg::sample_t c1,
    output logic                accum_clear,
    output logic                div_start,
    cluster_stats_if.ctrl       stats,
    output logic                cluster_id_we,
    output logic                cluster_id_wdata,
    output logic                lab_clear,
    output logic                done_kmeans,
    output logic                done_cluster
);
    import kmeans_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_KM_ADDR,
        S_KM_DATA,
        S_KM_WAIT,
        S_KM_WRITE,
        S_DIV,
        S_SELECT,
        S_RL_ADDR,
        S_RL_DATA,
        S_RL_WRITE
    } state_t;

    state_t state;
    count_t iter;
    logic   selected;
    logic   last_pixel;
    logic   last_iter;

    assign last_pixel = (pixel_addr == addr_t'(num_pixels - 1));
    assign last_iter  = (iter == count_t'(iterations - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= S_IDLE;
            pixel_addr    <= '0;
            iter          <= '0;
            sample_valid  <= 1'b0;
            accum_clear   <= 1'b0;
            div_start     <= 1'b0;
            cluster_id_we <= 1'b0;
            lab_clear     <= 1'b0;
            done_kmeans   <= 1'b0;
            done_cluster  <= 1'b0;
        end
        else
        begin
            // strobes last one cycle
            sample_valid  <= 1'b0;
            accum_clear   <= 1'b0;
            div_start     <= 1'b0;
            cluster_id_we <= 1'b0;
            lab_clear     <= 1'b0;

            case (state)
                S_IDLE:
                    if (start)
                    begin
                        pixel_addr   <= '0;
                        iter         <= '0;
                        c0           <= sample_t'(`KM_C0_INIT);
                        c1           <= sample_t'(`KM_C1_INIT);
                        accum_clear  <= 1'b1;
                        done_kmeans  <= 1'b0;
                        done_cluster <= 1'b0;
                        state        <= S_KM_ADDR;
                    end

                ////////////////////////////////////////////////////////////////////////////
                // k-means pass, one pixel at a time
                ////////////////////////////////////////////////////////////////////////////
                // memory answers one cycle after the address
                S_KM_ADDR:
                    state <= S_KM_DATA;
                S_KM_DATA:
                begin
                    sample       <= a_data;
                    sample_valid <= 1'b1;
                    state        <= S_KM_WAIT;
                end
                S_KM_WAIT:
                    if (decision_valid)
                    begin
                        cluster_id_we    <= 1'b1;
                        cluster_id_wdata <= decision;
                        state            <= S_KM_WRITE;
                    end
                S_KM_WRITE:
                    if (last_pixel)
                    begin
                        pixel_addr <= '0;
                        div_start  <= 1'b1;
                        state      <= S_DIV;
                    end
                    else
                    begin
                        pixel_addr <= pixel_addr + 1'b1;
                        state      <= S_KM_ADDR;
                    end
                S_DIV:
                    if (div_done)
                    begin
                        c0 <= new_c0;
                        c1 <= new_c1;
                        // keep the last pass stats for selection
                        if (last_iter)
                        begin
                            done_kmeans <= 1'b1;
                            state       <= S_SELECT;
                        end
                        else
                        begin
                            iter        <= iter + 1'b1;
                            accum_clear <= 1'b1;
                            state       <= S_KM_ADDR;
                        end
                    end

                ////////////////////////////////////////////////////////////////////////////
                // selection and relabel pass
                ////////////////////////////////////////////////////////////////////////////
                S_SELECT:
                begin
                    // ties go to cluster 0
                    selected <= (stats.neg1 > stats.neg0);
                    state    <= S_RL_ADDR;
                end
                S_RL_ADDR:
                    state <= S_RL_DATA;
                S_RL_DATA:
                begin
                    cluster_id_we <= 1'b1;
                    if (cluster_id_rdata != selected)
                    begin
                        cluster_id_wdata <= 1'b0;
                        lab_clear        <= 1'b1;
                    end
                    else
                    begin
                        cluster_id_wdata <= 1'b1;
                        lab_clear        <= rgb_dark;
                    end
                    state <= S_RL_WRITE;
                end
                S_RL_WRITE:
                    if (last_pixel)
                    begin
                        done_cluster <= 1'b1;
                        state        <= S_IDLE;
                    end
                    else
                    begin
                        pixel_addr <= pixel_addr + 1'b1;
                        state      <= S_RL_ADDR;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

/* verilog/kmeans_top.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module kmeans_top #(
    parameter int num_pixels = `KM_NUM_PIXELS,
    parameter int iterations = `KM_ITERATIONS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    output kmeans_pkg::addr_t   pixel_addr,
    input  kmeans_pkg::sample_t a_data,
    input  logic                cluster_id_rdata,
    input  logic                rgb_dark,
    output logic                cluster_id_we,
    output logic                cluster_id_wdata,
    output logic                lab_clear,
    output logic                done_kmeans,
    output logic                done_cluster
);
    import kmeans_pkg::*;

    logic    sample_valid;
    logic    decision_valid;
    logic    decision;
    logic    accum_clear;
    logic    div_start;
    logic    div_done;
    sample_t sample;
    sample_t c0;
    sample_t c1;
    sample_t new_c0;
    sample_t new_c1;

    // per-cluster statistics shared by accumulator, divider and controller
    cluster_stats_if i_stats ();

    kmeans_ctrl #(
        .num_pixels (num_pixels),
        .iterations (iterations)
    ) i_ctrl (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .a_data           (a_data),
        .cluster_id_rdata (cluster_id_rdata),
        .rgb_dark         (rgb_dark),
        .decision_valid   (decision_valid),
        .decision         (decision),
        .div_done         (div_done),
        .new_c0           (new_c0),
        .new_c1           (new_c1),
        .pixel_addr       (pixel_addr),
        .sample_valid     (sample_valid),
        .sample           (sample),
        .c0               (c0),
        .c1               (c1),
        .accum_clear      (accum_clear),
        .div_start        (div_start),
        .stats            (i_stats.ctrl),
        .cluster_id_we    (cluster_id_we),
        .cluster_id_wdata (cluster_id_wdata),
        .lab_clear        (lab_clear),
        .done_kmeans      (done_kmeans),
        .done_cluster     (done_cluster)
    );

    nearest_centroid i_nearest (
        .clk            (clk),
        .reset          (reset),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .c0             (c0),
        .c1             (c1),
        .decision_valid (decision_valid),
        .decision       (decision)
    );

    cluster_accum i_accum (
        .clk            (clk),
        .reset          (reset),
        .accum_clear    (accum_clear),
        .decision_valid (decision_valid),
        .decision       (decision),
        .sample         (sample),
        .stats          (i_stats.accum)
    );

    centroid_divider i_divider (
        .clk       (clk),
        .reset     (reset),
        .div_start (div_start),
        .c0        (c0),
        .c1        (c1),
        .stats     (i_stats.divide),
        .div_done  (div_done),
        .new_c0    (new_c0),
        .new_c1    (new_c1)
    );

endmodule

/* bench/kmeans_chk.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module kmeans_chk #(
    parameter int num_pixels = `KM_NUM_PIXELS
) (
    input logic              clk,
    input logic              reset,
    input kmeans_pkg::addr_t pixel_addr,
    input logic              cluster_id_we,
    input logic              lab_clear,
    input logic              done_kmeans,
    input logic              done_cluster
);

    // clear strobe only travels with a write
    a_clear_with_write: assert property (
        @(posedge clk) disable iff (reset) lab_clear |-> cluster_id_we
    ) else $error("lab_clear without cluster_id_we");

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset) cluster_id_we |-> (pixel_addr < num_pixels)
    ) else $error("write address beyond the image");

    // both done levels start low
    a_done_after_reset: assert property (
        @(posedge clk) reset |=> (!done_kmeans && !done_cluster)
    ) else $error("done output high right after reset");

    a_done_order: assert property (
        @(posedge clk) disable iff (reset) done_cluster |-> done_kmeans
    ) else $error("done_cluster without done_kmeans");

endmodule

bind kmeans_top kmeans_chk #(
    .num_pixels (num_pixels)
) i_chk (
    .clk           (clk),
    .reset         (reset),
    .pixel_addr    (pixel_addr),
    .cluster_id_we (cluster_id_we),
    .lab_clear     (lab_clear),
    .done_kmeans   (done_kmeans),
    .done_cluster  (done_cluster)
);

/* bench/tb_kmeans.sv */
`timescale 1ns/1ps
`include "kmeans_params.svh"

module tb_kmeans;
    import kmeans_pkg::*;

    localparam int NUM_PIXELS   = `KM_NUM_PIXELS;
    localparam int ITER         = `KM_ITERATIONS;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;

    // pattern kinds
    localparam int PAT_GROUPS = 0;
    localparam int PAT_ONE    = 1;
    localparam int PAT_THRESH = 2;
    localparam int PAT_RANDOM = 3;

    // case table of pattern kind and percentage of dark pixels
    localparam int NUM_CASES = 6;
    int case_kind [NUM_CASES] = '{PAT_GROUPS, PAT_ONE, PAT_THRESH, PAT_RANDOM, PAT_RANDOM,
                                  PAT_GROUPS};
    int case_dark [NUM_CASES] = '{0, 50, 25, 10, 90, 100};

    // generous per-pixel bound plus divider time per pass
    localparam int     PIXEL_CYCLES = 8;
    localparam longint CASE_CYCLES  = NUM_PIXELS * (ITER + 1) * PIXEL_CYCLES
                                      + ITER * (`KM_SUM_W + 1) + 16;
    localparam longint WATCHDOG_NS  = (NUM_CASES * CASE_CYCLES + RESET_CYCLES + 16) * CLK_PERIOD;

    logic    clk;
    logic    reset;
    logic    start;
    addr_t   pixel_addr;
    sample_t a_data;
    logic    cluster_id_rdata;
    logic    rgb_dark;
    logic    cluster_id_we;
    logic    cluster_id_wdata;
    logic    lab_clear;
    logic    done_kmeans;
    logic    done_cluster;

    // memory models
    int    a_mem    [NUM_PIXELS];
    logic  id_mem   [NUM_PIXELS];
    logic  dark_mem [NUM_PIXELS];
    logic  cleared  [NUM_PIXELS];
    addr_t addr_q;

    // reference results
    logic exp_id    [ITER][NUM_PIXELS];
    logic exp_final [NUM_PIXELS];
    logic exp_clear [NUM_PIXELS];
    logic empty_seen;

    int   seed = 32'h628c_6925;
    int   wr_pass;
    int   wr_index;
    logic done_kmeans_q;
    logic done_cluster_q;
    logic start_q;

    kmeans_top #(
        .num_pixels (NUM_PIXELS),
        .iterations (ITER)
    ) i_dut (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .pixel_addr       (pixel_addr),
        .a_data           (a_data),
        .cluster_id_rdata (cluster_id_rdata),
        .rgb_dark         (rgb_dark),
        .cluster_id_we    (cluster_id_we),
        .cluster_id_wdata (cluster_id_wdata),
        .lab_clear        (lab_clear),
        .done_kmeans      (done_kmeans),
        .done_cluster     (done_cluster)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic fill_memories(input int kind, input int dark_pct);
        int r;
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            case (kind)
                PAT_GROUPS: a_mem[p] = (p < NUM_PIXELS / 2) ? -40 + (p % 7) : 30 - (p % 5);
                // first pass fills only cluster 1 and leaves c0 at its start value
                // a pixel at 3 then sits exactly between c0 and the new c1
                PAT_ONE:    a_mem[p] = (p % 2 == 0) ? 3 : 9;
                PAT_THRESH: a_mem[p] = `KM_NEG_THRESH - 2 + (p % 5);
                default:
                begin
                    r = $random(seed);
                    a_mem[p] = r % 100;
                end
            endcase
            r = $random(seed);
            dark_mem[p] = ((r & 32'h7fff_ffff) % 100) < dark_pct;
        end
    endtask

    task automatic compute_reference();
        int   c0;
        int   c1;
        int   sum [2];
        int   cnt [2];
        int   neg [2];
        logic id;
        logic sel;
        c0 = `KM_C0_INIT;
        c1 = `KM_C1_INIT;
        empty_seen = 1'b0;
        for (int it = 0; it < ITER; it++)
        begin
            sum = '{0, 0};
            cnt = '{0, 0};
            neg = '{0, 0};
            for (int p = 0; p < NUM_PIXELS; p++)
            begin
                id = abs_diff(a_mem[p], c1) < abs_diff(a_mem[p], c0);
                exp_id[it][p] = id;
                sum[id] += a_mem[p];
                cnt[id] += 1;
                if (a_mem[p] < `KM_NEG_THRESH)
                    neg[id] += 1;
            end
            if (cnt[0] == 0 || cnt[1] == 0)
                empty_seen = 1'b1;
            // truncating division where an empty cluster keeps its centroid
            if (cnt[0] != 0)
                c0 = sum[0] / cnt[0];
            if (cnt[1] != 0)
                c1 = sum[1] / cnt[1];
        end
        sel = (neg[1] > neg[0]);
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            exp_final[p] = (exp_id[ITER-1][p] == sel);
            exp_clear[p] = (exp_id[ITER-1][p] != sel) || dark_mem[p];
        end
    endtask

    // memories answer one cycle after the address
    always @(posedge clk)
    begin
        #1;
        a_data           = sample_t'(a_mem[addr_q]);
        cluster_id_rdata = id_mem[addr_q];
        rgb_dark         = dark_mem[addr_q];
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_write();
        check_value("pixel_addr", 32'(pixel_addr), 32'(wr_index));
        if (wr_pass < ITER)
        begin
            check_value("cluster_id_wdata", 32'(cluster_id_wdata), 32'(exp_id[wr_pass][wr_index]));
            check_value("lab_clear", 32'(lab_clear), 32'h0);
        end
        else if (wr_pass == ITER)
        begin
            check_value("cluster_id_wdata", 32'(cluster_id_wdata), 32'(exp_final[wr_index]));
            check_value("lab_clear", 32'(lab_clear), 32'(exp_clear[wr_index]));
        end
        else
            report_failure("cluster id write after the relabel pass had finished");
        id_mem[wr_index] = cluster_id_wdata;
        wr_index++;
        if (wr_index == NUM_PIXELS)
        begin
            wr_index = 0;
            wr_pass++;
        end
    endtask

    always @(negedge clk)
    begin
        addr_q = pixel_addr;
        if (!reset)
        begin
            if (start)
            begin
                wr_pass  = 0;
                wr_index = 0;
                for (int p = 0; p < NUM_PIXELS; p++)
                    cleared[p] = 1'b0;
            end
            if (lab_clear && !cluster_id_we)
                report_failure("lab_clear strobe without a cluster id write");
            if (lab_clear)
                cleared[pixel_addr] = 1'b1;
            if (done_cluster && !done_kmeans)
                report_failure("done_cluster is high while done_kmeans is low");
            if (done_kmeans && !done_kmeans_q)
                check_value("writes_at_done_kmeans", 32'(wr_pass * NUM_PIXELS + wr_index),
                            32'(ITER * NUM_PIXELS));
            if (((done_kmeans_q && !done_kmeans) || (done_cluster_q && !done_cluster)) && !start_q)
                report_failure("a done output fell before the next start");
            if (cluster_id_we)
                check_write();
        end
        done_kmeans_q  = done_kmeans;
        done_cluster_q = done_cluster;
        start_q        = start;
    end

    task automatic run_case(input int k);
        fill_memories(case_kind[k], case_dark[k]);
        compute_reference();
        if (case_kind[k] == PAT_ONE && !empty_seen)
            report_failure("the one-group case never left a cluster empty");
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        @(negedge clk);
        check_value("done_kmeans", 32'(done_kmeans), 32'h0);
        check_value("done_cluster", 32'(done_cluster), 32'h0);
        while (!done_cluster)
            @(negedge clk);
        check_value("write_count", 32'(wr_pass * NUM_PIXELS + wr_index),
                    32'((ITER + 1) * NUM_PIXELS));
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            check_value("final_cluster_id", 32'(id_mem[p]), 32'(exp_final[p]));
            check_value("lab_cleared", 32'(cleared[p]), 32'(exp_clear[p]));
        end
    endtask

    initial
    begin
        reset            = 1'b1;
        start            = 1'b0;
        a_data           = '0;
        cluster_id_rdata = 1'b0;
        rgb_dark         = 1'b0;
        addr_q           = '0;
        wr_pass          = 0;
        wr_index         = 0;
        done_kmeans_q    = 1'b0;
        done_cluster_q   = 1'b0;
        start_q          = 1'b0;
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            id_mem[p]   = 1'b0;
            dark_mem[p] = 1'b0;
            cleared[p]  = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("done_kmeans", 32'(done_kmeans), 32'h0);
        check_value("done_cluster", 32'(done_cluster), 32'h0);
        for (int k = 0; k < NUM_CASES; k++)
            run_case(k);
        $display("PASS: all tests");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        report_failure("timeout, the engine did not finish all cases in time");
    end

endmodule

/* flist.f */
+incdir+include
verilog/kmeans_pkg.sv
verilog/cluster_stats_if.sv
verilog/nearest_centroid.sv
verilog/cluster_accum.sv
verilog/centroid_divider.sv
verilog/kmeans_ctrl.sv
verilog/kmeans_top.sv
bench/kmeans_chk.sv
bench/tb_kmeans.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_kmeans
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
